// ==== hw/pad_pkg.sv ====
//==============================
// Pad input package
// Report, pad and stage payload
// types for the controller path
//==============================
`default_nettype none

package pad_pkg;

	// Report and pad geometry
	localparam int LLAPI_BUTTON_W = 32;
	localparam int PAD_W = 12;
	localparam int NUM_USB = 5;
	localparam int NUM_PLAYERS = 5;

	// Output flow control
	localparam int OUT_CREDITS = 4;
	localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

	// Controller type byte
	// Any value not listed here is treated as a generic pad
	typedef enum logic [7:0] {
		CTRL_NONE       = 8'd0,
		CTRL_SATURN     = 8'd3,
		CTRL_SATURN_ALT = 8'd8,
		CTRL_INVALID    = 8'd255
	} llapi_ctrl_e;

	typedef struct packed {
		logic [LLAPI_BUTTON_W-1:0] buttons;
		llapi_ctrl_e               ctrl;
		logic                      link_en;
	} llapi_report_t;

	// Console pad layout, top bit first
	typedef struct packed {
		logic start;
		logic select;
		logic r;
		logic l;
		logic y;
		logic x;
		logic b;
		logic a;
		logic up;
		logic down;
		logic left;
		logic right;
	} snes_pad_t;

	//==============================
	// Stage payloads
	//==============================
	typedef struct packed {
		llapi_report_t               report_a;
		llapi_report_t               report_b;
		snes_pad_t [NUM_USB-1:0]     usb;
	} pad_sample_t;

	typedef struct packed {
		llapi_report_t               report_a;
		llapi_report_t               report_b;
		logic                        use_a;
		logic                        use_b;
		snes_pad_t [NUM_USB-1:0]     usb;
	} presence_stage_t;

	typedef struct packed {
		snes_pad_t                   pad_a;
		snes_pad_t                   pad_b;
		logic                        use_a;
		logic                        use_b;
		logic                        menu_combo;
		snes_pad_t [NUM_USB-1:0]     usb;
	} remap_stage_t;

	typedef struct packed {
		snes_pad_t [NUM_PLAYERS-1:0] player;
		logic                        menu_combo;
	} player_frame_t;

endpackage

`default_nettype wire

// ==== hw/llapi_presence.sv ====
//==============================
// Serial-link presence stage
// Decides per port whether a
// usable controller is attached
//==============================
`default_nettype none

module llapi_presence (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  pad_pkg::pad_sample_t     in_item,
	input  wire                      in_valid,
	output logic                     in_ready,
	output pad_pkg::presence_stage_t out_item,
	output logic                     out_valid,
	input  wire                      out_advance
);
	import pad_pkg::*;

	logic seen_a;
	logic seen_b;
	logic accept;
	logic use_a;
	logic use_b;

	// Load when empty or when stage 2 takes the current item
	assign in_ready = !out_valid || out_advance;
	assign accept   = in_valid && in_ready;

	// Type byte must name a real controller
	function automatic logic type_ok(input llapi_ctrl_e ctrl);
		return (ctrl != CTRL_NONE) && (ctrl != CTRL_INVALID);
	endfunction

	// Current sample counts toward the button-seen condition
	assign use_a = in_item.report_a.link_en && type_ok(in_item.report_a.ctrl)
		&& (seen_a || (|in_item.report_a.buttons));
	assign use_b = in_item.report_b.link_en && type_ok(in_item.report_b.ctrl)
		&& (seen_b || (|in_item.report_b.buttons));

	// Sticky button flags
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			seen_a <= 1'b0;
			seen_b <= 1'b0;
		end else if (accept) begin
			if (|in_item.report_a.buttons)
				seen_a <= 1'b1;
			if (|in_item.report_b.buttons)
				seen_b <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			out_item.report_a <= in_item.report_a;
			out_item.report_b <= in_item.report_b;
			out_item.use_a    <= use_a;
			out_item.use_b    <= use_b;
			out_item.usb      <= in_item.usb;
		end
	end

	// Held item survives a downstream stall untouched
	a_hold_on_stall: assert property (@(posedge clk_sys) disable iff (reset)
		out_valid && !out_advance |=> out_valid && $stable(out_item));

endmodule

`default_nettype wire

// ==== hw/llapi_remap.sv ====
//==============================
// Serial-link button remap stage
// Maps reports to the console pad
// and flags the menu combination
//==============================
`default_nettype none

module llapi_remap (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  pad_pkg::presence_stage_t in_item,
	input  wire                      in_valid,
	output logic                     in_ready,
	output pad_pkg::remap_stage_t    out_item,
	output logic                     out_valid,
	input  wire                      out_advance
);
	import pad_pkg::*;

	logic      accept;
	snes_pad_t pad_a;
	snes_pad_t pad_b;
	logic      menu_combo;

	assign in_ready = !out_valid || out_advance;
	assign accept   = in_valid && in_ready;

	// Report buttons are HID usage ids minus one
	function automatic snes_pad_t remap_pad(input llapi_report_t rep);
		logic [LLAPI_BUTTON_W-1:0] btn;
		logic [PAD_W-1:0]          bits;
		snes_pad_t                 pad;
		btn  = rep.buttons;
		bits = {
			btn[5], btn[4],                  // start select
			btn[7], btn[6],                  // r l
			btn[2], btn[3], btn[0], btn[1],  // y x b a
			btn[27], btn[26], btn[25], btn[24]  // d-pad
		};
		pad = snes_pad_t'(bits);
		// Saturn pads have no select
		// Z takes its place and both right shoulders drive r
		if (rep.ctrl == CTRL_SATURN || rep.ctrl == CTRL_SATURN_ALT) begin
			pad.select = btn[6];
			pad.r      = btn[9] | btn[7];
			pad.l      = btn[8];
		end
		return pad;
	endfunction

	// Down + start + first button
	function automatic logic combo_held(input llapi_report_t rep);
		return rep.buttons[26] && rep.buttons[5] && rep.buttons[0];
	endfunction

	assign pad_a = remap_pad(in_item.report_a);
	assign pad_b = remap_pad(in_item.report_b);

	// Raw buttons only, presence is ignored here
	assign menu_combo = combo_held(in_item.report_a) || combo_held(in_item.report_b);

	always_ff @(posedge clk_sys) begin
		if (reset)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			out_item.pad_a      <= pad_a;
			out_item.pad_b      <= pad_b;
			out_item.use_a      <= in_item.use_a;
			out_item.use_b      <= in_item.use_b;
			out_item.menu_combo <= menu_combo;
			out_item.usb        <= in_item.usb;
		end
	end

endmodule

`default_nettype wire

// ==== hw/player_slot_router.sv ====
//==============================
// Player slot router
// Places serial-link pads first
// and shifts USB pads behind them
//==============================
`default_nettype none

module player_slot_router (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  pad_pkg::remap_stage_t  in_item,
	input  wire                    in_valid,
	output logic                   in_ready,
	output pad_pkg::player_frame_t frame,
	output logic                   out_valid,
	input  wire                    credit_return
);
	import pad_pkg::*;

	player_frame_t        next_frame;
	player_frame_t        frame_q;
	logic                 frame_valid;
	logic [CREDIT_W-1:0]  credit_cnt;
	logic                 accept;
	logic                 send;

	//==============================
	// Slot assignment
	//==============================
	always_comb begin
		next_frame.menu_combo = in_item.menu_combo;
		case ({in_item.use_a, in_item.use_b})
			2'b11: begin
				next_frame.player[0] = in_item.pad_a;
				next_frame.player[1] = in_item.pad_b;
				next_frame.player[2] = in_item.usb[0];
				next_frame.player[3] = in_item.usb[1];
				next_frame.player[4] = in_item.usb[2];
			end
			2'b10: begin
				next_frame.player[0] = in_item.pad_a;
				next_frame.player[1] = in_item.usb[0];
				next_frame.player[2] = in_item.usb[1];
				next_frame.player[3] = in_item.usb[2];
				next_frame.player[4] = in_item.usb[3];
			end
			// Port B keeps player 2, USB pad 0 moves up to player 1
			2'b01: begin
				next_frame.player[0] = in_item.usb[0];
				next_frame.player[1] = in_item.pad_b;
				next_frame.player[2] = in_item.usb[1];
				next_frame.player[3] = in_item.usb[2];
				next_frame.player[4] = in_item.usb[3];
			end
			default: begin
				for (int i = 0; i < NUM_PLAYERS; i++)
					next_frame.player[i] = in_item.usb[i];
			end
		endcase
	end

	//==============================
	// Output register and credits
	//==============================
	assign send      = out_valid;
	assign out_valid = frame_valid && (credit_cnt != '0);
	assign in_ready  = !frame_valid || send;
	assign accept    = in_valid && in_ready;
	assign frame     = frame_q;

	always_ff @(posedge clk_sys) begin
		if (reset)
			frame_valid <= 1'b0;
		else if (in_ready)
			frame_valid <= in_valid;
	end

	always_ff @(posedge clk_sys) begin
		if (accept)
			frame_q <= next_frame;
	end

	// Send and return in the same cycle cancel out
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			credit_cnt <= CREDIT_W'(OUT_CREDITS);
		end else begin
			case ({send, credit_return})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	a_credit_bound: assert property (@(posedge clk_sys) disable iff (reset)
		credit_cnt <= CREDIT_W'(OUT_CREDITS));

	// A full counter means the consumer holds no credit to give back
	a_no_excess_return: assert property (@(posedge clk_sys) disable iff (reset)
		credit_return |-> credit_cnt != CREDIT_W'(OUT_CREDITS));

endmodule

`default_nettype wire

// ==== hw/pad_input_top.sv ====
//==============================
// Pad input top level
// Presence, remap and slot router
// chained as a 3-stage pipeline
//==============================
`default_nettype none

module pad_input_top (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  pad_pkg::pad_sample_t   sample,
	input  wire                    in_valid,
	output logic                   in_ready,
	output pad_pkg::player_frame_t frame,
	output logic                   out_valid,
	input  wire                    credit_return
);
	import pad_pkg::*;

	// Stage 1 to stage 2
	presence_stage_t s1_item;
	logic            s1_valid;
	logic            s1_advance;

	// Stage 2 to stage 3
	remap_stage_t    s2_item;
	logic            s2_valid;
	logic            s2_advance;

	llapi_presence presence (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.in_item     (sample),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.out_item    (s1_item),
		.out_valid   (s1_valid),
		.out_advance (s1_advance)
	);

	llapi_remap remap (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.in_item     (s1_item),
		.in_valid    (s1_valid),
		.in_ready    (s1_advance),
		.out_item    (s2_item),
		.out_valid   (s2_valid),
		.out_advance (s2_advance)
	);

	player_slot_router router (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.in_item       (s2_item),
		.in_valid      (s2_valid),
		.in_ready      (s2_advance),
		.frame         (frame),
		.out_valid     (out_valid),
		.credit_return (credit_return)
	);

endmodule

`default_nettype wire

// ==== tb/tb_pad_input.sv ====
//==============================
// Pad input testbench
// Random and directed samples
// checked against a reference
// model under output credits
//==============================
`default_nettype none

module tb_pad_input;
	timeunit 1ns;
	timeprecision 1ps;
	import pad_pkg::*;

	localparam int LIMIT = 200;
	localparam int MODE_GENERIC = 0;
	localparam int MODE_SATURN = 1;
	localparam int MODE_MIXED = 2;
	// Buttons 26, 5 and 0
	localparam logic [31:0] COMBO = 32'h0400_0021;

	logic          clk_sys;
	logic          reset;
	pad_sample_t   sample;
	logic          in_valid;
	logic          in_ready;
	player_frame_t frame;
	logic          out_valid;
	logic          credit_return = 1'b0;

	player_frame_t exp_q[$];
	int            acc_q[$];
	int            cyc = 0;
	int            owed = 0;
	int            frames_seen = 0;
	int            checks = 0;
	int            errors = 0;
	int            timeouts = 0;
	logic          ref_seen_a;
	logic          ref_seen_b;
	logic          hold_credits;
	logic          fast_credits;
	logic          check_latency;

	pad_input_top UUT (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.sample        (sample),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.frame         (frame),
		.out_valid     (out_valid),
		.credit_return (credit_return)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
	end

	//==============================
	// Reference model
	//==============================
	// Pad bits straight from the button index table
	function automatic snes_pad_t ref_pad(input llapi_report_t rep);
		snes_pad_t p;
		logic      sat;
		sat      = (rep.ctrl == CTRL_SATURN) || (rep.ctrl == CTRL_SATURN_ALT);
		p.start  = rep.buttons[5];
		p.select = sat ? rep.buttons[6] : rep.buttons[4];
		p.r      = sat ? (rep.buttons[9] | rep.buttons[7]) : rep.buttons[7];
		p.l      = sat ? rep.buttons[8] : rep.buttons[6];
		p.y      = rep.buttons[2];
		p.x      = rep.buttons[3];
		p.b      = rep.buttons[0];
		p.a      = rep.buttons[1];
		p.up     = rep.buttons[27];
		p.down   = rep.buttons[26];
		p.left   = rep.buttons[25];
		p.right  = rep.buttons[24];
		return p;
	endfunction

	function automatic logic ref_used(input llapi_report_t rep, input logic seen);
		return rep.link_en && (rep.ctrl != CTRL_NONE) && (rep.ctrl != CTRL_INVALID)
			&& (seen || (rep.buttons != '0));
	endfunction

	// Sticky flags follow the order in which samples are accepted
	function automatic player_frame_t expected_frame(input pad_sample_t s);
		player_frame_t f;
		snes_pad_t     slots[$];
		logic          use_a;
		logic          use_b;
		use_a      = ref_used(s.report_a, ref_seen_a);
		use_b      = ref_used(s.report_b, ref_seen_b);
		ref_seen_a = ref_seen_a || (s.report_a.buttons != '0);
		ref_seen_b = ref_seen_b || (s.report_b.buttons != '0);
		for (int i = 0; i < NUM_USB; i++)
			slots.push_back(s.usb[i]);
		// Port A takes slot 0, port B slot 1, USB pads fill the rest
		if (use_a)
			slots.insert(0, ref_pad(s.report_a));
		if (use_b)
			slots.insert(1, ref_pad(s.report_b));
		for (int i = 0; i < NUM_PLAYERS; i++)
			f.player[i] = slots[i];
		f.menu_combo = ((s.report_a.buttons & COMBO) == COMBO)
			|| ((s.report_b.buttons & COMBO) == COMBO);
		return f;
	endfunction

	//==============================
	// Stimulus
	//==============================
	function automatic llapi_report_t random_report(input int mode);
		llapi_report_t r;
		logic [7:0]    t;
		r.buttons = $urandom();
		if (r.buttons == '0)
			r.buttons = 32'h1;
		r.link_en = 1'b1;
		case (mode)
			MODE_SATURN: t = ($urandom_range(1) == 0) ? 8'd3 : 8'd8;
			MODE_MIXED: begin
				case ($urandom_range(4))
					0: t = 8'd0;
					1: t = 8'd255;
					2: t = 8'd8;
					default: t = 8'($urandom());
				endcase
				r.link_en = 1'($urandom_range(1));
				if ($urandom_range(1) == 0)
					r.buttons = '0;
			end
			default: begin
				t = 8'($urandom_range(254, 1));
				while (t == 8'd3 || t == 8'd8)
					t = 8'($urandom_range(254, 1));
			end
		endcase
		if ($urandom_range(3) == 0)
			r.buttons = r.buttons | COMBO;
		r.ctrl = llapi_ctrl_e'(t);
		return r;
	endfunction

	function automatic pad_sample_t random_sample(input int mode);
		pad_sample_t s;
		s.report_a = random_report(mode);
		s.report_b = random_report(mode);
		for (int i = 0; i < NUM_USB; i++)
			s.usb[i] = snes_pad_t'(12'($urandom()));
		return s;
	endfunction

	// Called on a falling edge, returns on the falling edge after acceptance
	task automatic send_sample(input pad_sample_t s);
		int t;
		sample   = s;
		in_valid = 1'b1;
		t = 0;
		while (!in_ready) begin
			if (t == LIMIT)
				abort_on_timeout("in_ready while offering a sample");
			@(negedge clk_sys);
			t++;
		end
		exp_q.push_back(expected_frame(s));
		acc_q.push_back(cyc);
		@(negedge clk_sys);
	endtask

	task automatic send_directed(
		input logic [7:0]  ctrl_a,
		input logic        en_a,
		input logic [31:0] btn_a,
		input logic [7:0]  ctrl_b,
		input logic        en_b,
		input logic [31:0] btn_b
	);
		pad_sample_t s;
		s = random_sample(MODE_GENERIC);
		s.report_a.ctrl    = llapi_ctrl_e'(ctrl_a);
		s.report_a.link_en = en_a;
		s.report_a.buttons = btn_a;
		s.report_b.ctrl    = llapi_ctrl_e'(ctrl_b);
		s.report_b.link_en = en_b;
		s.report_b.buttons = btn_b;
		send_sample(s);
	endtask

	task automatic idle_input();
		in_valid = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic apply_reset();
		reset    = 1'b1;
		in_valid = 1'b0;
		repeat (8) @(negedge clk_sys);
		reset      = 1'b0;
		ref_seen_a = 1'b0;
		ref_seen_b = 1'b0;
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("in_ready", in_ready, 1'b1);
	endtask

	task automatic drain_pipeline();
		int t;
		in_valid = 1'b0;
		t = 0;
		while (exp_q.size() != 0 || owed != 0) begin
			if (t == LIMIT)
				abort_on_timeout("the pipeline to drain");
			@(negedge clk_sys);
			t++;
		end
	endtask

	//==============================
	// Checks and reporting
	//==============================
	task automatic check_pad(input string name, input snes_pad_t got, input snes_pad_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("MISMATCH %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("MISMATCH %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		timeouts++;
		$display("Timeout while waiting for %s", what);
		finish_run();
	endtask

	// Frame compare and credit consumer
	always @(negedge clk_sys) begin
		player_frame_t want;
		int            acc;
		if (reset) begin
			credit_return = 1'b0;
			owed          = 0;
		end else begin
			// Only credits already spent go back
			credit_return = (owed > 0) && !hold_credits
				&& (fast_credits || $urandom_range(2) == 0);
			if (credit_return)
				owed--;
			if (out_valid) begin
				owed++;
				frames_seen++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("Frame delivered while none was expected");
				end else begin
					want = exp_q.pop_front();
					acc  = acc_q.pop_front();
					for (int i = 0; i < NUM_PLAYERS; i++)
						check_pad($sformatf("frame.player[%0d]", i), frame.player[i],
							want.player[i]);
					check_flag("frame.menu_combo", frame.menu_combo, want.menu_combo);
					// Three register stages between sample and frame
					if (check_latency && (cyc - acc != 3)) begin
						errors++;
						$display("Frame latency was %0d cycles instead of 3", cyc - acc);
					end
				end
			end
		end
	end

	//==============================
	// Test sequence
	//==============================
	initial begin
		int t;
		void'($urandom(94377));
		reset         = 1'b1;
		in_valid      = 1'b0;
		sample        = '0;
		hold_credits  = 1'b0;
		fast_credits  = 1'b1;
		check_latency = 1'b1;
		@(negedge clk_sys);
		apply_reset();

		// Generic pads at full rate with fixed latency
		repeat (24) send_sample(random_sample(MODE_GENERIC));
		drain_pipeline();
		check_latency = 1'b0;
		fast_credits  = 1'b0;

		// Saturn layouts, then mixed types, links and menu combos
		repeat (24) send_sample(random_sample(MODE_SATURN));
		for (int i = 0; i < 80; i++) begin
			send_sample(random_sample(MODE_MIXED));
			if ($urandom_range(3) == 0)
				idle_input();
		end
		drain_pipeline();

		// Presence after a second reset, slot shifts, combo on unused ports
		apply_reset();
		send_directed(8'd5, 1'b1, '0, 8'd3, 1'b1, '0);
		send_directed(8'd0, 1'b1, 32'h1, 8'd255, 1'b1, 32'h2);
		send_directed(8'd5, 1'b0, 32'h10, 8'd3, 1'b0, 32'h10);
		send_directed(8'd5, 1'b1, '0, 8'd3, 1'b0, '0);
		send_directed(8'd5, 1'b0, '0, 8'd8, 1'b1, '0);
		send_directed(8'd0, 1'b1, COMBO, 8'd5, 1'b0, '0);
		send_directed(8'd5, 1'b1, '0, 8'd3, 1'b1, COMBO);
		drain_pipeline();

		// Credits held back, then released
		hold_credits = 1'b1;
		frames_seen  = 0;
		fork
			begin
				repeat (10) send_sample(random_sample(MODE_GENERIC));
				idle_input();
			end
			begin
				t = 0;
				while (in_ready) begin
					if (t == LIMIT)
						abort_on_timeout("in_ready to fall under back-pressure");
					@(negedge clk_sys);
					t++;
				end
				repeat (10) @(negedge clk_sys);
				if (frames_seen != OUT_CREDITS) begin
					errors++;
					$display("%0d frames left while credits were held, expected %0d",
						frames_seen, OUT_CREDITS);
				end
				hold_credits = 1'b0;
			end
		join
		drain_pipeline();

		finish_run();
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/pad_pkg.sv
hw/llapi_presence.sv
hw/llapi_remap.sv
hw/player_slot_router.sv
hw/pad_input_top.sv
tb/tb_pad_input.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pad input testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f verilog.f --top-module tb_pad_input -o tb_pad_input

./obj_dir/tb_pad_input > sim.log
cat sim.log

if grep -q "tests failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without a reported failure"
